/* project.f */
design/dma_pkg.sv
design/dma_sync_fifo.sv
design/dma_burst_counter.sv
design/dma_read_src_fsm.sv
design/dma_write_dst_fsm.sv
design/dma_copy_top.sv
verification/dma_copy_assert.sv
verification/dma_copy_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module dma_copy_tb -f project.f -Mdir obj_dir
	out="$$(./obj_dir/Vdma_copy_tb)"; echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* verification/dma_copy_tb.sv */
// copy engine testbench with AXI memory models of 4096 words each
// addresses wrap at 32 KB; random stalls come from an LCG seeded with 24
module dma_copy_tb;
   import dma_pkg::*;

   localparam int DATA_W         = 64;
   localparam int MAX_BURST_LEN  = 16;
   localparam int FIFO_DEPTH     = 32;
   localparam int MEM_WORDS      = 4096;
   // 8 byte beats
   localparam int AXI_SIZE       = 3;
   localparam int TIMEOUT_CYCLES = 20000;

   typedef struct {
      int unsigned count;
      int unsigned last_len;
   } t_bursts;

   logic              clk        = 1'b0;
   logic              reset_n    = 1'b0;
   logic              desc_valid = 1'b0;
   t_dma_descriptor   desc       = '0;
   logic              arready    = 1'b0;
   logic              rvalid     = 1'b0;
   logic [DATA_W-1:0] rdata      = '0;
   t_axi_resp         rresp      = OKAY;
   logic              rlast      = 1'b0;
   logic              awready    = 1'b0;
   logic              wready     = 1'b0;
   logic              bvalid     = 1'b0;
   t_axi_resp         bresp      = OKAY;
   logic              desc_ready;
   logic              arvalid;
   t_axi_ar           ar;
   logic              rready;
   logic              awvalid;
   t_axi_ar           aw;
   logic              wvalid;
   logic [DATA_W-1:0] wdata;
   logic              wlast;
   logic              bready;
   t_dma_status       status;

   logic [DATA_W-1:0] src_mem [MEM_WORDS];
   logic [DATA_W-1:0] dst_mem [MEM_WORDS];
   t_axi_ar           ar_log [$];
   t_axi_ar           aw_log [$];
   int unsigned       w_count     = 0;
   logic              stall_en    = 1'b0;
   logic [31:0]       stall_state = 32'd24;
   logic [31:0]       err_addr    = '1;
   logic [31:0]       rd_addr     = '0;
   int unsigned       rd_left     = 0;
   logic              rd_active   = 1'b0;
   logic [31:0]       wr_addr     = '0;
   logic              wr_active   = 1'b0;
   logic              b_pending   = 1'b0;
   int unsigned       cycles      = 0;
   int unsigned       errors      = 0;
   int unsigned       tests_run   = 0;
   int unsigned       tests_bad   = 0;

   dma_copy_top #(
      .DATA_W        (DATA_W),
      .MAX_BURST_LEN (MAX_BURST_LEN),
      .FIFO_DEPTH    (FIFO_DEPTH)
   ) u_dut (
      .clk        (clk),
      .reset_n    (reset_n),
      .desc_valid (desc_valid),
      .desc_ready (desc_ready),
      .desc       (desc),
      .arvalid    (arvalid),
      .arready    (arready),
      .ar         (ar),
      .rvalid     (rvalid),
      .rready     (rready),
      .rdata      (rdata),
      .rresp      (rresp),
      .rlast      (rlast),
      .awvalid    (awvalid),
      .awready    (awready),
      .aw         (aw),
      .wvalid     (wvalid),
      .wready     (wready),
      .wdata      (wdata),
      .wlast      (wlast),
      .bvalid     (bvalid),
      .bready     (bready),
      .bresp      (bresp),
      .status     (status)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic int unsigned word_index(input logic [31:0] addr);
      return int'((addr >> 3) % MEM_WORDS);
   endfunction

   // about one stall in four per channel
   function automatic logic stall_bit(input int k);
      return stall_en && (stall_state[16 + 3 * k +: 2] == 2'b00);
   endfunction

   // burst count and beats in the final burst
   function automatic t_bursts expected_bursts(input int unsigned length);
      t_bursts     r;
      int unsigned beats;
      beats      = (length == 0) ? 1 : length;
      r.count    = (beats + MAX_BURST_LEN - 1) / MAX_BURST_LEN;
      r.last_len = beats - (r.count - 1) * MAX_BURST_LEN;
      return r;
   endfunction

   always @(posedge clk) begin
      stall_state <= lcg_next(stall_state);
   end

   // read memory, one burst at a time
   always @(posedge clk) begin
      if (!reset_n) begin
         arready   <= 1'b0;
         rvalid    <= 1'b0;
         rlast     <= 1'b0;
         rresp     <= OKAY;
         rd_active <= 1'b0;
         rd_left   <= 0;
         ar_log.delete();
      end else begin
         if (arvalid && arready) begin
            ar_log.push_back(ar);
            rd_addr   <= ar.addr;
            rd_left   <= 32'(ar.len) + 32'd1;
            rd_active <= 1'b1;
            arready   <= 1'b0;
         end else begin
            arready <= arvalid && !rd_active && !stall_bit(0);
         end
         if (rvalid && rready && rlast) begin
            rvalid    <= 1'b0;
            rlast     <= 1'b0;
            rd_active <= 1'b0;
         end else if (rd_active && (!rvalid || rready)) begin
            if (rd_left != 0 && !stall_bit(1)) begin
               rvalid  <= 1'b1;
               rdata   <= src_mem[word_index(rd_addr)];
               rlast   <= rd_left == 1;
               rresp   <= (rd_addr == err_addr) ? SLVERR : OKAY;
               rd_addr <= rd_addr + 32'd8;
               rd_left <= rd_left - 1;
            end else begin
               rvalid <= 1'b0;
            end
         end
      end
   end

   // write memory, response after each wlast
   always @(posedge clk) begin
      if (!reset_n) begin
         awready   <= 1'b0;
         wready    <= 1'b0;
         bvalid    <= 1'b0;
         bresp     <= OKAY;
         wr_active <= 1'b0;
         b_pending <= 1'b0;
         w_count   <= 0;
         aw_log.delete();
      end else begin
         if (awvalid && awready) begin
            aw_log.push_back(aw);
            wr_addr   <= aw.addr;
            wr_active <= 1'b1;
            awready   <= 1'b0;
         end else begin
            awready <= awvalid && !wr_active && !b_pending && !stall_bit(2);
         end
         if (wvalid && wready) begin
            dst_mem[word_index(wr_addr)] <= wdata;
            wr_addr <= wr_addr + 32'd8;
            w_count <= w_count + 1;
            if (wlast) begin
               wr_active <= 1'b0;
               b_pending <= 1'b1;
            end
         end
         wready <= wr_active && !(wvalid && wready && wlast) && !stall_bit(3);
         if (bvalid && bready) begin
            bvalid    <= 1'b0;
            b_pending <= 1'b0;
         end else if (b_pending && !bvalid && !stall_bit(4)) begin
            bvalid <= 1'b1;
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the copies did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failed");
         $finish;
      end
   end

   task automatic compare_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
      if (expected !== actual) begin
         $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic apply_reset();
      reset_n <= 1'b0;
      repeat (2) @(posedge clk);
      reset_n <= 1'b1;
      @(posedge clk);
   endtask

   task automatic push_desc(input logic [31:0] src, input logic [31:0] dst,
                            input logic [15:0] len);
      @(posedge clk);
      desc_valid <= 1'b1;
      desc       <= '{src_addr: src, dst_addr: dst, length: len, go: 1'b1};
      do @(posedge clk); while (!desc_ready);
      desc_valid <= 1'b0;
   endtask

   task automatic wait_descriptors(input int unsigned count);
      while (status.descriptor_count != 16'(count)) @(posedge clk);
   endtask

   // consumes this descriptor's bursts from the logs
   task automatic verify_copy(input string name, input logic [31:0] src,
                              input logic [31:0] dst, input int unsigned len);
      t_bursts     eb;
      t_axi_ar     got;
      int unsigned exp_len;
      logic [31:0] step;
      eb   = expected_bursts(len);
      step = 32'(MAX_BURST_LEN * DATA_W / 8);
      for (int unsigned k = 0; k < eb.count; k++) begin
         exp_len = (k == eb.count - 1) ? eb.last_len - 1 : MAX_BURST_LEN - 1;
         if (ar_log.size() == 0 || aw_log.size() == 0) begin
            $display("%s: burst %0d was never requested on AR or AW", name, k);
            errors++;
         end else begin
            got = ar_log.pop_front();
            compare_value({name, " ar addr"}, src + k * step, got.addr);
            compare_value({name, " ar len"}, exp_len, got.len);
            compare_value({name, " ar size"}, AXI_SIZE, got.size);
            compare_value({name, " ar burst"}, BURST_INCR, got.burst);
            got = aw_log.pop_front();
            compare_value({name, " aw addr"}, dst + k * step, got.addr);
            compare_value({name, " aw len"}, exp_len, got.len);
            compare_value({name, " aw size"}, AXI_SIZE, got.size);
            compare_value({name, " aw burst"}, BURST_INCR, got.burst);
         end
      end
      for (int unsigned i = 0; i < len; i++) begin
         compare_value({name, " data"}, src_mem[word_index(src + 8 * i)],
                       dst_mem[word_index(dst + 8 * i)]);
      end
   endtask

   task automatic end_test(input string name, input int unsigned errs_before);
      tests_run++;
      if (errors == errs_before) begin
         $display("[pass] %s", name);
      end else begin
         tests_bad++;
         $display("[FAIL] %s", name);
      end
   endtask

   initial begin
      logic [31:0] seed;
      int unsigned errs_before;
      seed = 32'd24;
      // upper half random, lower half the byte address
      for (int i = 0; i < MEM_WORDS; i++) begin
         seed       = lcg_next(seed);
         src_mem[i] = {seed, 32'(i * 8)};
      end

      apply_reset();
      errs_before = errors;
      push_desc(32'h0100, 32'h4100, 16'd5);
      wait_descriptors(1);
      verify_copy("single_copy", 32'h0100, 32'h4100, 5);
      compare_value("single_copy beats", 5, w_count);
      compare_value("single_copy extra bursts", 0, ar_log.size() + aw_log.size());
      end_test("single_copy", errs_before);

      apply_reset();
      errs_before = errors;
      push_desc(32'h0400, 32'h4400, 16'd37);
      wait_descriptors(1);
      verify_copy("multi_burst", 32'h0400, 32'h4400, 37);
      compare_value("multi_burst beats", 37, w_count);
      compare_value("multi_burst extra bursts", 0, ar_log.size() + aw_log.size());
      end_test("multi_burst", errs_before);

      apply_reset();
      errs_before = errors;
      push_desc(32'h1000, 32'h5000, 16'd7);
      push_desc(32'h1400, 32'h5400, 16'd32);
      push_desc(32'h1800, 32'h5800, 16'd20);
      wait_descriptors(3);
      // busy drops on the same edge the last count lands
      compare_value("queued busy", 0, status.busy);
      verify_copy("queued", 32'h1000, 32'h5000, 7);
      verify_copy("queued", 32'h1400, 32'h5400, 32);
      verify_copy("queued", 32'h1800, 32'h5800, 20);
      compare_value("queued beats", 59, w_count);
      end_test("queued", errs_before);

      apply_reset();
      errs_before = errors;
      stall_en <= 1'b1;
      push_desc(32'h2000, 32'h6000, 16'd50);
      wait_descriptors(1);
      verify_copy("back_pressure", 32'h2000, 32'h6000, 50);
      compare_value("back_pressure rd_valid_cnt", 50, status.perf.rd_valid_cnt);
      // at least one cycle per beat plus one address cycle per burst
      compare_value("back_pressure rd_clk_cnt lower bound", 1,
                    status.perf.rd_clk_cnt >= 32'd54);
      stall_en <= 1'b0;
      end_test("back_pressure", errs_before);

      apply_reset();
      errs_before = errors;
      err_addr <= 32'h3000 + 32'd160;
      push_desc(32'h3000, 32'h7000, 16'd40);
      while (!status.stopped_on_error) @(posedge clk);
      // flags must stay put with no reset applied
      repeat (20) @(posedge clk);
      compare_value("read_error stopped_on_error", 1, status.stopped_on_error);
      compare_value("read_error rd_rsp_err", 1, status.rd_rsp_err);
      compare_value("read_error count", 0, status.descriptor_count);
      compare_value("read_error rready", 0, rready);
      err_addr <= '1;
      apply_reset();
      compare_value("read_error flags after reset", 0,
                    {status.stopped_on_error, status.rd_rsp_err});
      end_test("read_error", errs_before);

      $display("summary: %0d tests, %0d failing tests, %0d failed checks",
               tests_run, tests_bad, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* verification/dma_copy_assert.sv */
// AXI handshake and status rules on the copy engine top level
// checks are off while reset_n is low; W beats follow their own AW
module dma_copy_assert (
   input logic             clk,
   input logic             reset_n,
   input logic             arvalid,
   input logic             arready,
   input dma_pkg::t_axi_ar ar,
   input logic             awvalid,
   input logic             awready,
   input dma_pkg::t_axi_ar aw,
   input logic             wvalid,
   input logic             wready,
   input logic             wlast,
   input logic             desc_rdack,
   input logic             busy
);

   logic [7:0] aw_len;
   logic [7:0] w_beats;

   // beat position inside the current write burst
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         aw_len  <= '0;
         w_beats <= '0;
      end else begin
         if (awvalid && awready) begin
            aw_len <= aw.len;
         end
         if (wvalid && wready) begin
            w_beats <= wlast ? '0 : w_beats + 8'd1;
         end
      end
   end

   ar_hold: assert property (@(posedge clk) disable iff (!reset_n)
      arvalid && !arready |=> arvalid && $stable(ar))
      else $error("arvalid dropped or AR payload changed before arready");

   aw_hold: assert property (@(posedge clk) disable iff (!reset_n)
      awvalid && !awready |=> awvalid && $stable(aw))
      else $error("awvalid dropped or AW payload changed before awready");

   wlast_valid: assert property (@(posedge clk) disable iff (!reset_n)
      (wvalid || wlast) |-> wvalid && (wlast == (w_beats == aw_len)))
      else $error("wlast high without wvalid or not on the final beat of the burst");

   // descriptor pop only from an active transfer
   rdack_busy: assert property (@(posedge clk) disable iff (!reset_n)
      desc_rdack |-> busy)
      else $error("descriptor popped while not busy");

endmodule

bind dma_copy_top dma_copy_assert u_assert (
   .clk        (clk),
   .reset_n    (reset_n),
   .arvalid    (arvalid),
   .arready    (arready),
   .ar         (ar),
   .awvalid    (awvalid),
   .awready    (awready),
   .aw         (aw),
   .wvalid     (wvalid),
   .wready     (wready),
   .wlast      (wlast),
   .desc_rdack (desc_rdack),
   .busy       (status.busy)
);

/* design/dma_copy_top.sv */
// memory to memory copy engine with AXI4 read and write masters
// descriptors run one at a time; write responses are not checked
module dma_copy_top #(
   parameter int DATA_W        = 64,
   parameter int MAX_BURST_LEN = 16,
   parameter int FIFO_DEPTH    = 32
) (
   input  logic                     clk,
   input  logic                     reset_n,
   input  logic                     desc_valid,
   output logic                     desc_ready,
   input  dma_pkg::t_dma_descriptor desc,
   output logic                     arvalid,
   input  logic                     arready,
   output dma_pkg::t_axi_ar         ar,
   input  logic                     rvalid,
   output logic                     rready,
   input  logic [DATA_W-1:0]        rdata,
   input  dma_pkg::t_axi_resp       rresp,
   input  logic                     rlast,
   output logic                     awvalid,
   input  logic                     awready,
   output dma_pkg::t_axi_ar         aw,
   output logic                     wvalid,
   input  logic                     wready,
   output logic [DATA_W-1:0]        wdata,
   output logic                     wlast,
   input  logic                     bvalid,
   output logic                     bready,
   input  dma_pkg::t_axi_resp       bresp,
   output dma_pkg::t_dma_status     status
);
   import dma_pkg::*;

   t_dma_descriptor   desc_head;
   logic              desc_empty;
   logic              desc_full;
   logic              desc_rdack;
   logic              wr_start;
   logic              wr_done;
   logic              fifo_wr_en;
   logic [DATA_W-1:0] fifo_wr_data;
   logic              fifo_rd_en;
   logic [DATA_W-1:0] fifo_rd_data;
   logic              fifo_empty;
   logic              fifo_almost_full;

   assign desc_ready = ~desc_full;

   dma_sync_fifo #(
      .T            (t_dma_descriptor),
      .DEPTH        (4),
      .AFULL_MARGIN (1)
   ) u_desc_fifo (
      .clk         (clk),
      .reset_n     (reset_n),
      .wr_en       (desc_valid),
      .wr_data     (desc),
      .rd_en       (desc_rdack),
      .rd_data     (desc_head),
      .empty       (desc_empty),
      .full        (desc_full),
      .almost_full ()
   );

   // margin of two covers the registered write from the read side
   dma_sync_fifo #(
      .T            (logic [DATA_W-1:0]),
      .DEPTH        (FIFO_DEPTH),
      .AFULL_MARGIN (2)
   ) u_data_fifo (
      .clk         (clk),
      .reset_n     (reset_n),
      .wr_en       (fifo_wr_en),
      .wr_data     (fifo_wr_data),
      .rd_en       (fifo_rd_en),
      .rd_data     (fifo_rd_data),
      .empty       (fifo_empty),
      .full        (),
      .almost_full (fifo_almost_full)
   );

   dma_read_src_fsm #(
      .DATA_W        (DATA_W),
      .MAX_BURST_LEN (MAX_BURST_LEN)
   ) u_rd (
      .clk              (clk),
      .reset_n          (reset_n),
      .desc             (desc_head),
      .desc_not_empty   (~desc_empty),
      .desc_rdack       (desc_rdack),
      .wr_start         (wr_start),
      .wr_done          (wr_done),
      .arvalid          (arvalid),
      .arready          (arready),
      .ar               (ar),
      .rvalid           (rvalid),
      .rready           (rready),
      .rdata            (rdata),
      .rresp            (rresp),
      .rlast            (rlast),
      .fifo_wr_en       (fifo_wr_en),
      .fifo_wr_data     (fifo_wr_data),
      .fifo_almost_full (fifo_almost_full),
      .status           (status)
   );

   dma_write_dst_fsm #(
      .DATA_W        (DATA_W),
      .MAX_BURST_LEN (MAX_BURST_LEN)
   ) u_wr (
      .clk          (clk),
      .reset_n      (reset_n),
      .desc         (desc_head),
      .wr_start     (wr_start),
      .wr_done      (wr_done),
      .awvalid      (awvalid),
      .awready      (awready),
      .aw           (aw),
      .wvalid       (wvalid),
      .wready       (wready),
      .wdata        (wdata),
      .wlast        (wlast),
      .bvalid       (bvalid),
      .bready       (bready),
      .fifo_rd_data (fifo_rd_data),
      .fifo_empty   (fifo_empty),
      .fifo_rd_en   (fifo_rd_en)
   );

endmodule

/* design/dma_write_dst_fsm.sv */
// write side, drains the data FIFO into INCR bursts with full strobes
// bresp is not checked
module dma_write_dst_fsm #(
   parameter int DATA_W        = 64,
   parameter int MAX_BURST_LEN = 16
) (
   input  logic                     clk,
   input  logic                     reset_n,
   input  dma_pkg::t_dma_descriptor desc,
   input  logic                     wr_start,
   output logic                     wr_done,
   output logic                     awvalid,
   input  logic                     awready,
   output dma_pkg::t_axi_ar         aw,
   output logic                     wvalid,
   input  logic                     wready,
   output logic [DATA_W-1:0]        wdata,
   output logic                     wlast,
   input  logic                     bvalid,
   output logic                     bready,
   input  logic [DATA_W-1:0]        fifo_rd_data,
   input  logic                     fifo_empty,
   output logic                     fifo_rd_en
);
   import dma_pkg::*;

   localparam logic [2:0] AXI_SIZE = 3'($clog2(DATA_W / 8));

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ADDR,
      ST_DATA,
      ST_RESP
   } t_wr_state;

   t_wr_state         state;
   logic              w_beat;
   logic              final_burst;
   logic [ADDR_W-1:0] burst_addr;
   logic [7:0]        burst_len;
   logic              last_beat;
   logic              last_burst;

   assign wvalid     = (state == ST_DATA) & ~fifo_empty;
   assign wdata      = fifo_rd_data;
   assign wlast      = wvalid & last_beat;
   assign w_beat     = wvalid & wready;
   assign fifo_rd_en = w_beat;
   assign bready     = state == ST_RESP;

   assign aw = t_axi_ar'{addr: burst_addr, len: burst_len, size: AXI_SIZE, burst: BURST_INCR};

   dma_burst_counter #(
      .DATA_W        (DATA_W),
      .MAX_BURST_LEN (MAX_BURST_LEN)
   ) u_cnt (
      .clk        (clk),
      .reset_n    (reset_n),
      .load       (wr_start),
      .base_addr  (desc.dst_addr),
      .length     (desc.length),
      .beat       (w_beat),
      .burst_addr (burst_addr),
      .burst_len  (burst_len),
      .last_beat  (last_beat),
      .last_burst (last_burst)
   );

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state       <= ST_IDLE;
         awvalid     <= 1'b0;
         wr_done     <= 1'b0;
         final_burst <= 1'b0;
      end else begin
         wr_done <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (wr_start) begin
                  awvalid <= 1'b1;
                  state   <= ST_ADDR;
               end
            end
            ST_ADDR: begin
               if (awready) begin
                  awvalid <= 1'b0;
                  state   <= ST_DATA;
               end
            end
            ST_DATA: begin
               // counter moves on at this beat, so keep the flag
               if (w_beat && last_beat) begin
                  final_burst <= last_burst;
                  state       <= ST_RESP;
               end
            end
            ST_RESP: begin
               if (bvalid) begin
                  if (final_burst) begin
                     wr_done <= 1'b1;
                     state   <= ST_IDLE;
                  end else begin
                     awvalid <= 1'b1;
                     state   <= ST_ADDR;
                  end
               end
            end
         endcase
      end
   end

endmodule

/* design/dma_read_src_fsm.sv */
// read side, one descriptor at a time; beats go to the data FIFO a cycle late
// an SLVERR response parks the machine in error until reset
module dma_read_src_fsm #(
   parameter int DATA_W        = 64,
   parameter int MAX_BURST_LEN = 16
) (
   input  logic                     clk,
   input  logic                     reset_n,
   input  dma_pkg::t_dma_descriptor desc,
   input  logic                     desc_not_empty,
   output logic                     desc_rdack,
   output logic                     wr_start,
   input  logic                     wr_done,
   output logic                     arvalid,
   input  logic                     arready,
   output dma_pkg::t_axi_ar         ar,
   input  logic                     rvalid,
   output logic                     rready,
   input  logic [DATA_W-1:0]        rdata,
   input  dma_pkg::t_axi_resp       rresp,
   input  logic                     rlast,
   output logic                     fifo_wr_en,
   output logic [DATA_W-1:0]        fifo_wr_data,
   input  logic                     fifo_almost_full,
   output dma_pkg::t_dma_status     status
);
   import dma_pkg::*;

   localparam logic [2:0] AXI_SIZE   = 3'($clog2(DATA_W / 8));
   localparam int         NUM_STATES = 5;

   typedef enum int unsigned {
      IDLE_BIT,
      ADDR_SETUP_BIT,
      COPY_BIT,
      WAIT_WR_BIT,
      ERROR_BIT
   } t_state_bit;

   typedef enum logic [NUM_STATES-1:0] {
      IDLE       = NUM_STATES'(1) << IDLE_BIT,
      ADDR_SETUP = NUM_STATES'(1) << ADDR_SETUP_BIT,
      COPY       = NUM_STATES'(1) << COPY_BIT,
      WAIT_WR    = NUM_STATES'(1) << WAIT_WR_BIT,
      ERROR      = NUM_STATES'(1) << ERROR_BIT
   } t_state;

   t_state                 state;
   t_state                 next;
   logic                   load;
   logic                   rd_beat;
   logic                   busy;
   logic [LENGTH_W-1:0]    descriptor_count;
   logic [PERF_CNTR_W-1:0] clk_cnt;
   logic [PERF_CNTR_W-1:0] valid_cnt;
   logic [ADDR_W-1:0]      burst_addr;
   logic [7:0]             burst_len;
   logic                   last_burst;

   assign load       = state[IDLE_BIT] & desc.go & desc_not_empty;
   assign rready     = state[COPY_BIT] & ~fifo_almost_full;
   assign rd_beat    = rvalid & rready;
   assign desc_rdack = state[WAIT_WR_BIT] & wr_done;

   assign ar = t_axi_ar'{addr: burst_addr, len: burst_len, size: AXI_SIZE, burst: BURST_INCR};

   assign status = t_dma_status'{
      busy:             busy,
      stopped_on_error: state[ERROR_BIT],
      rd_rsp_err:       state[ERROR_BIT],
      descriptor_count: descriptor_count,
      perf:             t_dma_perf_cntr'{rd_clk_cnt: clk_cnt, rd_valid_cnt: valid_cnt}
   };

   dma_burst_counter #(
      .DATA_W        (DATA_W),
      .MAX_BURST_LEN (MAX_BURST_LEN)
   ) u_cnt (
      .clk        (clk),
      .reset_n    (reset_n),
      .load       (load),
      .base_addr  (desc.src_addr),
      .length     (desc.length),
      .beat       (rd_beat),
      .burst_addr (burst_addr),
      .burst_len  (burst_len),
      .last_beat  (),
      .last_burst (last_burst)
   );

   always_comb begin
      next = state;
      unique case (1'b1)
         state[IDLE_BIT]: begin
            if (load) next = ADDR_SETUP;
         end
         state[ADDR_SETUP_BIT]: begin
            if (arvalid && arready) next = COPY;
         end
         state[COPY_BIT]: begin
            if (rd_beat && rresp == SLVERR) next = ERROR;
            else if (rd_beat && rlast) next = last_burst ? WAIT_WR : ADDR_SETUP;
         end
         state[WAIT_WR_BIT]: begin
            if (wr_done) next = IDLE;
         end
         state[ERROR_BIT]: begin
            next = ERROR;
         end
         default: begin
            next = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state            <= IDLE;
         arvalid          <= 1'b0;
         wr_start         <= 1'b0;
         fifo_wr_en       <= 1'b0;
         busy             <= 1'b0;
         descriptor_count <= '0;
         clk_cnt          <= '0;
         valid_cnt        <= '0;
      end else begin
         state      <= next;
         wr_start   <= load;
         fifo_wr_en <= rd_beat;
         if (desc_rdack) begin
            descriptor_count <= descriptor_count + LENGTH_W'(1);
         end
         if (load) begin
            clk_cnt   <= '0;
            valid_cnt <= '0;
         end else if (state[ADDR_SETUP_BIT] || state[COPY_BIT]) begin
            clk_cnt   <= clk_cnt + PERF_CNTR_W'(1);
            valid_cnt <= valid_cnt + PERF_CNTR_W'(rd_beat);
         end
         // outputs set on entry to the next state
         unique case (1'b1)
            next[IDLE_BIT]: begin
               busy    <= 1'b0;
               arvalid <= 1'b0;
            end
            next[ADDR_SETUP_BIT]: begin
               busy    <= 1'b1;
               arvalid <= 1'b1;
            end
            next[COPY_BIT], next[WAIT_WR_BIT], next[ERROR_BIT]: begin
               arvalid <= 1'b0;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rd_beat) begin
         fifo_wr_data <= rdata;
      end
   end

endmodule

/* design/dma_burst_counter.sv */
// splits one descriptor into bursts of MAX_BURST_LEN beats
// MAX_BURST_LEN must be a power of two no larger than 256
module dma_burst_counter #(
   parameter int DATA_W        = 64,
   parameter int MAX_BURST_LEN = 16
) (
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic                         load,
   input  logic [dma_pkg::ADDR_W-1:0]   base_addr,
   input  logic [dma_pkg::LENGTH_W-1:0] length,
   input  logic                         beat,
   output logic [dma_pkg::ADDR_W-1:0]   burst_addr,
   output logic [7:0]                   burst_len,
   output logic                         last_beat,
   output logic                         last_burst
);
   import dma_pkg::*;

   localparam logic [ADDR_W-1:0]   BURST_BYTES = ADDR_W'(MAX_BURST_LEN * (DATA_W / 8));
   localparam logic [LENGTH_W-1:0] MAX_LEN     = LENGTH_W'(MAX_BURST_LEN);
   localparam logic [7:0]          FULL_LEN    = 8'(MAX_BURST_LEN - 1);

   logic [LENGTH_W-1:0] len_m1;
   logic [LENGTH_W-1:0] bursts_m1;
   logic [LENGTH_W-1:0] burst_idx;
   logic [7:0]          tail_len;
   logic [7:0]          beat_cnt;

   // zero length runs as one beat
   assign len_m1 = (length == '0) ? '0 : length - LENGTH_W'(1);

   assign last_burst = burst_idx == bursts_m1;
   assign burst_len  = last_burst ? tail_len : FULL_LEN;
   assign last_beat  = beat_cnt == burst_len;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         bursts_m1 <= '0;
         burst_idx <= '0;
         beat_cnt  <= '0;
      end else if (load) begin
         bursts_m1 <= len_m1 / MAX_LEN;
         burst_idx <= '0;
         beat_cnt  <= '0;
      end else if (beat) begin
         if (last_beat) begin
            beat_cnt  <= '0;
            burst_idx <= burst_idx + LENGTH_W'(1);
         end else begin
            beat_cnt <= beat_cnt + 8'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         burst_addr <= base_addr;
         tail_len   <= 8'(len_m1 % MAX_LEN);
      end else if (beat && last_beat) begin
         // next burst starts right after this one
         burst_addr <= burst_addr + BURST_BYTES;
      end
   end

endmodule

/* design/dma_sync_fifo.sv */
// single clock FIFO, head word visible on rd_data while not empty
// writes when full and reads when empty are dropped
module dma_sync_fifo #(
   parameter type T            = logic,
   parameter int  DEPTH        = 4,
   parameter int  AFULL_MARGIN = 2
) (
   input  logic clk,
   input  logic reset_n,
   input  logic wr_en,
   input  T     wr_data,
   input  logic rd_en,
   output T     rd_data,
   output logic empty,
   output logic full,
   output logic almost_full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = PTR_W + 1;

   T mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_wr;
   logic             do_rd;

   assign do_wr = wr_en & ~full;
   assign do_rd = rd_en & ~empty;

   assign empty       = count == '0;
   assign full        = count == CNT_W'(DEPTH);
   // raised with AFULL_MARGIN or fewer slots left
   assign almost_full = count >= CNT_W'(DEPTH - AFULL_MARGIN);
   assign rd_data     = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + CNT_W'(1);
            2'b01:   count <= count - CNT_W'(1);
            default: count <= count;
         endcase
      end
   end

endmodule

/* design/dma_pkg.sv */
// shared types for the DMA copy engine
// every burst is INCR with full strobes; data width lives in module parameters
package dma_pkg;

   localparam int ADDR_W      = 32;
   localparam int LENGTH_W    = 16;
   localparam int PERF_CNTR_W = 32;

   // descriptor, length counted in data beats
   typedef struct packed {
      logic [ADDR_W-1:0]   src_addr;
      logic [ADDR_W-1:0]   dst_addr;
      logic [LENGTH_W-1:0] length;
      logic                go;
   } t_dma_descriptor;

   // read side counters, cleared per descriptor
   typedef struct packed {
      logic [PERF_CNTR_W-1:0] rd_clk_cnt;
      logic [PERF_CNTR_W-1:0] rd_valid_cnt;
   } t_dma_perf_cntr;

   typedef struct packed {
      logic                busy;
      logic                stopped_on_error;
      logic                rd_rsp_err;
      logic [LENGTH_W-1:0] descriptor_count;
      t_dma_perf_cntr      perf;
   } t_dma_status;

   // address channel, used for both AR and AW
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [7:0]        len;
      logic [2:0]        size;
      logic [1:0]        burst;
   } t_axi_ar;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } t_axi_resp;

   localparam logic [1:0] BURST_INCR = 2'b01;

endpackage
